//--- hw/wcache_pkg.sv
// Weight cache sizes, widths and controller state type
`default_nettype none

package wcache_pkg;

    // ==================================================
    // Array sizes and widths
    // ==================================================
    localparam int n_port  = 4;     // PE rows
    localparam int port_w  = 2;     // Row number
    localparam int wram_aw = 13;    // Weight RAM address
    localparam int wram_dw = 8;     // Weight word
    localparam int idx_w   = 8;     // Index tag
    localparam int hit_len = 32;    // Hit table entries
    localparam int hit_aw  = 5;     // Hit table slot number

    // Controller states
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_cfg  = 2'd1,
        st_work = 2'd2
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/wcache_ctrl.sv
// Configuration FSM with bypass flag and index stream ready
`timescale 1ns/1ps
`default_nettype none

module wcache_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic cfg_info_vld,
    input  logic cfg_wbuf_ena,
    output logic cfg_info_rdy,
    output logic mtow_dat_rdy,
    output logic state_work,
    output logic bypass
);
    import wcache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (cfg_info_vld) begin
                    state_nxt = st_cfg;
                end
            end
            st_cfg:  state_nxt = st_work;   // Always one cycle
            st_work: begin
                if (cfg_info_vld) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= st_idle;
            bypass <= 1'b0;
        end else begin
            state <= state_nxt;
            // Mode is taken on the step into work
            if (state == st_cfg) begin
                bypass <= !cfg_wbuf_ena;
            end
        end
    end

    assign cfg_info_rdy = (state == st_idle);
    assign state_work   = (state == st_work);
    assign mtow_dat_rdy = state_work;   // Index stream only in work

endmodule

`default_nettype wire

//--- hw/hit_table.sv
// Hit table with tag preload, miss fill, last access register and per-row lookup
`timescale 1ns/1ps
`default_nettype none

module hit_table (
    input  logic                                                      clk,
    input  logic                                                      rst_n,
    input  logic                                                      state_work,
    input  logic                                                      bypass,
    input  logic                                                      mtow_dat_vld,
    input  logic                                                      mtow_dat_rdy,
    input  logic [wcache_pkg::idx_w-1:0]                              mtow_dat_dat,
    input  logic [wcache_pkg::n_port-1:0]                             ptow_add_vld,
    input  logic [wcache_pkg::n_port-1:0][wcache_pkg::wram_aw-1:0]    ptow_add_add,
    input  logic [wcache_pkg::n_port-1:0][wcache_pkg::idx_w-1:0]      ptow_add_buf,
    input  logic                                                      fill_en,
    input  logic [wcache_pkg::hit_aw-1:0]                             fill_slot,
    input  logic [wcache_pkg::wram_aw-1:0]                            resp_addr,
    input  logic [wcache_pkg::wram_dw-1:0]                            wram_dat_dat,
    input  logic                                                      resp_done,
    output logic [wcache_pkg::n_port-1:0]                             local_hit,
    output logic [wcache_pkg::n_port-1:0][wcache_pkg::wram_dw-1:0]    local_data,
    output logic [wcache_pkg::n_port-1:0]                             tag_match,
    output logic [wcache_pkg::n_port-1:0][wcache_pkg::hit_aw-1:0]     tag_slot
);
    import wcache_pkg::*;

    logic [idx_w-1:0]   tag_mem  [hit_len];
    logic [wram_dw-1:0] data_mem [hit_len];
    logic [hit_len-1:0] tag_vld;
    logic [hit_len-1:0] data_vld;
    logic [hit_aw-1:0]  wr_ptr;         // Round-robin preload slot
    logic               preload_we;
    logic               fill_we;

    logic [wram_aw-1:0] last_addr;
    logic [wram_dw-1:0] last_data;
    logic               last_vld;

    // ==================================================
    // Table update
    // ==================================================
    assign preload_we = state_work && !bypass && mtow_dat_vld && mtow_dat_rdy;
    assign fill_we    = state_work && resp_done && fill_en;

    always_ff @(posedge clk) begin
        if (preload_we) begin
            tag_mem[wr_ptr] <= mtow_dat_dat;
        end
        if (fill_we) begin
            data_mem[fill_slot] <= wram_dat_dat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_vld  <= '0;
            data_vld <= '0;
            wr_ptr   <= '0;
        end else if (!state_work) begin
            tag_vld  <= '0;
            data_vld <= '0;
            wr_ptr   <= '0;
        end else begin
            if (fill_we) begin
                data_vld[fill_slot] <= 1'b1;
            end
            // New tag starts without data
            if (preload_we) begin
                tag_vld[wr_ptr]  <= 1'b1;
                data_vld[wr_ptr] <= 1'b0;
                wr_ptr           <= wr_ptr + 1'b1;
            end
        end
    end

    // Most recent RAM response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_vld <= 1'b0;
        end else if (!state_work) begin
            last_vld <= 1'b0;
        end else if (resp_done) begin
            last_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_done) begin
            last_addr <= resp_addr;
            last_data <= wram_dat_dat;
        end
    end

    // ==================================================
    // Per-row lookup
    // ==================================================
    always_comb begin
        for (int r = 0; r < n_port; r++) begin
            tag_match[r] = 1'b0;
            tag_slot[r]  = '0;
            // Downward scan so the lowest matching slot is kept
            for (int s = hit_len - 1; s >= 0; s--) begin
                if (tag_vld[s] && tag_mem[s] == ptow_add_buf[r]) begin
                    tag_match[r] = 1'b1;
                    tag_slot[r]  = hit_aw'(s);
                end
            end
        end
    end

    for (genvar r = 0; r < n_port; r++) begin : g_look
        logic tag_hit;
        logic last_hit;

        assign tag_hit  = tag_match[r] && data_vld[tag_slot[r]];
        assign last_hit = last_vld && ptow_add_add[r] == last_addr;

        assign local_hit[r]  = state_work && !bypass && ptow_add_vld[r] && (tag_hit || last_hit);
        assign local_data[r] = last_hit ? last_data : data_mem[tag_slot[r]];    // Last access wins
    end

endmodule

`default_nettype wire

//--- hw/miss_arbiter.sv
// Round-robin miss arbiter with RAM address issue and outstanding read tracking
`timescale 1ns/1ps
`default_nettype none

module miss_arbiter (
    input  logic                                                      clk,
    input  logic                                                      rst_n,
    input  logic                                                      state_work,
    input  logic [wcache_pkg::n_port-1:0]                             miss_req,
    input  logic [wcache_pkg::n_port-1:0][wcache_pkg::wram_aw-1:0]    ptow_add_add,
    input  logic [wcache_pkg::n_port-1:0]                             tag_match,
    input  logic [wcache_pkg::n_port-1:0][wcache_pkg::hit_aw-1:0]     tag_slot,
    input  logic                                                      wram_add_rdy,
    input  logic                                                      wram_dat_vld,
    input  logic                                                      wram_dat_rdy,
    output logic                                                      wram_add_vld,
    output logic [wcache_pkg::wram_aw-1:0]                            wram_add_add,
    output logic [wcache_pkg::n_port-1:0]                             miss_grant,
    output logic                                                      resp_pending,
    output logic [wcache_pkg::port_w-1:0]                             resp_port,
    output logic [wcache_pkg::wram_aw-1:0]                            resp_addr,
    output logic                                                      fill_en,
    output logic [wcache_pkg::hit_aw-1:0]                             fill_slot,
    output logic                                                      resp_done
);
    import wcache_pkg::*;

    logic [port_w-1:0] last_port;       // Row of the last grant
    logic [port_w-1:0] pick_port;
    logic              pick_vld;
    logic              issue;
    logic              add_hs;

    // ==================================================
    // Round-robin pick
    // ==================================================
    always_comb begin
        logic [port_w-1:0] cand;
        pick_vld  = 1'b0;
        pick_port = last_port;
        // Nearest row after last_port is assigned last and wins
        for (int k = n_port; k >= 1; k--) begin
            cand = last_port + port_w'(k);
            if (miss_req[cand]) begin
                pick_vld  = 1'b1;
                pick_port = cand;
            end
        end
    end

    assign issue     = state_work && !wram_add_vld && !resp_pending && pick_vld;
    assign add_hs    = wram_add_vld && wram_add_rdy;
    assign resp_done = resp_pending && wram_dat_vld && wram_dat_rdy;
    assign resp_addr = wram_add_add;    // Address stays until the next issue

    // ==================================================
    // Address phase and pending read
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wram_add_vld <= 1'b0;
            resp_pending <= 1'b0;
            last_port    <= '0;
            resp_port    <= '0;
            fill_en      <= 1'b0;
        end else if (!state_work) begin
            wram_add_vld <= 1'b0;
            resp_pending <= 1'b0;
        end else begin
            if (add_hs) begin
                wram_add_vld <= 1'b0;
                resp_pending <= 1'b1;
            end else if (issue) begin
                wram_add_vld <= 1'b1;
                last_port    <= pick_port;
                resp_port    <= pick_port;
                fill_en      <= tag_match[pick_port];   // Matched tag has no data yet
            end
            if (resp_done) begin
                resp_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            wram_add_add <= ptow_add_add[pick_port];
            fill_slot    <= tag_slot[pick_port];
        end
    end

    // Request accepted on the address handshake
    for (genvar r = 0; r < n_port; r++) begin : g_grant
        assign miss_grant[r] = add_hs && resp_port == port_w'(r);
    end

endmodule

`default_nettype wire

//--- hw/port_return.sv
// Per-row hit output registers, RAM data steering and request ready
`timescale 1ns/1ps
`default_nettype none

module port_return (
    input  logic                                                      clk,
    input  logic                                                      rst_n,
    input  logic                                                      state_work,
    input  logic [wcache_pkg::n_port-1:0]                             ptow_add_vld,
    input  logic [wcache_pkg::n_port-1:0]                             ptow_dat_rdy,
    input  logic [wcache_pkg::n_port-1:0]                             local_hit,
    input  logic [wcache_pkg::n_port-1:0][wcache_pkg::wram_dw-1:0]    local_data,
    input  logic [wcache_pkg::n_port-1:0]                             miss_grant,
    input  logic                                                      resp_pending,
    input  logic [wcache_pkg::port_w-1:0]                             resp_port,
    input  logic                                                      wram_dat_vld,
    input  logic [wcache_pkg::wram_dw-1:0]                            wram_dat_dat,
    output logic [wcache_pkg::n_port-1:0]                             miss_req,
    output logic [wcache_pkg::n_port-1:0]                             ptow_add_rdy,
    output logic [wcache_pkg::n_port-1:0]                             ptow_dat_vld,
    output logic [wcache_pkg::n_port-1:0][wcache_pkg::wram_dw-1:0]    ptow_dat_dat,
    output logic                                                      wram_dat_rdy
);
    import wcache_pkg::*;

    // RAM side follows the pending row
    assign wram_dat_rdy = state_work && resp_pending && ptow_dat_rdy[resp_port];

    for (genvar r = 0; r < n_port; r++) begin : g_row
        logic               resp_here;  // This row owns the pending read
        logic               hit_acc;
        logic               reg_vld;
        logic [wram_dw-1:0] reg_dat;

        assign resp_here = resp_pending && resp_port == port_w'(r);

        // Hit taken when the register is empty or drains this cycle
        assign hit_acc = local_hit[r] && !resp_here && (!reg_vld || ptow_dat_rdy[r]);

        // A waiting word or miss blocks the row so data stays in order
        assign miss_req[r] = state_work && ptow_add_vld[r] && !local_hit[r]
                             && !resp_here && !reg_vld;

        assign ptow_add_rdy[r] = hit_acc || miss_grant[r];

        // ==================================================
        // Hit output register
        // ==================================================
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                reg_vld <= 1'b0;
            end else if (!state_work) begin
                reg_vld <= 1'b0;
            end else if (hit_acc) begin
                reg_vld <= 1'b1;
            end else if (ptow_dat_rdy[r]) begin
                reg_vld <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (hit_acc) begin
                reg_dat <= local_data[r];
            end
        end

        // RAM word has priority on its own row
        assign ptow_dat_vld[r] = state_work && (resp_here ? wram_dat_vld : reg_vld);
        assign ptow_dat_dat[r] = resp_here ? wram_dat_dat : reg_dat;
    end

endmodule

`default_nettype wire

//--- hw/wcache_top.sv
// Weight cache top level with controller, hit table, miss arbiter and row return
`timescale 1ns/1ps
`default_nettype none

module wcache_top (
    input  logic                                                      clk,
    input  logic                                                      rst_n,
    input  logic                                                      cfg_info_vld,
    output logic                                                      cfg_info_rdy,
    input  logic                                                      cfg_wbuf_ena,
    input  logic                                                      mtow_dat_vld,
    output logic                                                      mtow_dat_rdy,
    input  logic [wcache_pkg::idx_w-1:0]                              mtow_dat_dat,
    input  logic [wcache_pkg::n_port-1:0]                             ptow_add_vld,
    output logic [wcache_pkg::n_port-1:0]                             ptow_add_rdy,
    input  logic [wcache_pkg::n_port-1:0][wcache_pkg::wram_aw-1:0]    ptow_add_add,
    input  logic [wcache_pkg::n_port-1:0][wcache_pkg::idx_w-1:0]      ptow_add_buf,
    output logic [wcache_pkg::n_port-1:0]                             ptow_dat_vld,
    input  logic [wcache_pkg::n_port-1:0]                             ptow_dat_rdy,
    output logic [wcache_pkg::n_port-1:0][wcache_pkg::wram_dw-1:0]    ptow_dat_dat,
    output logic                                                      wram_add_vld,
    input  logic                                                      wram_add_rdy,
    output logic [wcache_pkg::wram_aw-1:0]                            wram_add_add,
    input  logic                                                      wram_dat_vld,
    output logic                                                      wram_dat_rdy,
    input  logic [wcache_pkg::wram_dw-1:0]                            wram_dat_dat
);
    import wcache_pkg::*;

    logic                             state_work;
    logic                             bypass;
    logic [n_port-1:0]                local_hit;
    logic [n_port-1:0][wram_dw-1:0]   local_data;
    logic [n_port-1:0]                tag_match;
    logic [n_port-1:0][hit_aw-1:0]    tag_slot;
    logic [n_port-1:0]                miss_req;
    logic [n_port-1:0]                miss_grant;
    logic                             resp_pending;
    logic [port_w-1:0]                resp_port;
    logic [wram_aw-1:0]               resp_addr;
    logic                             fill_en;
    logic [hit_aw-1:0]                fill_slot;
    logic                             resp_done;

    wcache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_info_vld (cfg_info_vld),
        .cfg_wbuf_ena (cfg_wbuf_ena),
        .cfg_info_rdy (cfg_info_rdy),
        .mtow_dat_rdy (mtow_dat_rdy),
        .state_work   (state_work),
        .bypass       (bypass)
    );

    hit_table u_hit (
        .clk          (clk),
        .rst_n        (rst_n),
        .state_work   (state_work),
        .bypass       (bypass),
        .mtow_dat_vld (mtow_dat_vld),
        .mtow_dat_rdy (mtow_dat_rdy),
        .mtow_dat_dat (mtow_dat_dat),
        .ptow_add_vld (ptow_add_vld),
        .ptow_add_add (ptow_add_add),
        .ptow_add_buf (ptow_add_buf),
        .fill_en      (fill_en),
        .fill_slot    (fill_slot),
        .resp_addr    (resp_addr),
        .wram_dat_dat (wram_dat_dat),
        .resp_done    (resp_done),
        .local_hit    (local_hit),
        .local_data   (local_data),
        .tag_match    (tag_match),
        .tag_slot     (tag_slot)
    );

    miss_arbiter u_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .state_work   (state_work),
        .miss_req     (miss_req),
        .ptow_add_add (ptow_add_add),
        .tag_match    (tag_match),
        .tag_slot     (tag_slot),
        .wram_add_rdy (wram_add_rdy),
        .wram_dat_vld (wram_dat_vld),
        .wram_dat_rdy (wram_dat_rdy),
        .wram_add_vld (wram_add_vld),
        .wram_add_add (wram_add_add),
        .miss_grant   (miss_grant),
        .resp_pending (resp_pending),
        .resp_port    (resp_port),
        .resp_addr    (resp_addr),
        .fill_en      (fill_en),
        .fill_slot    (fill_slot),
        .resp_done    (resp_done)
    );

    port_return u_ret (
        .clk          (clk),
        .rst_n        (rst_n),
        .state_work   (state_work),
        .ptow_add_vld (ptow_add_vld),
        .ptow_dat_rdy (ptow_dat_rdy),
        .local_hit    (local_hit),
        .local_data   (local_data),
        .miss_grant   (miss_grant),
        .resp_pending (resp_pending),
        .resp_port    (resp_port),
        .wram_dat_vld (wram_dat_vld),
        .wram_dat_dat (wram_dat_dat),
        .miss_req     (miss_req),
        .ptow_add_rdy (ptow_add_rdy),
        .ptow_dat_vld (ptow_dat_vld),
        .ptow_dat_dat (ptow_dat_dat),
        .wram_dat_rdy (wram_dat_rdy)
    );

endmodule

`default_nettype wire

//--- verification/wcache_assert.sv
// Concurrent protocol checks for the weight cache, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module wcache_assert (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             state_work,
    input logic                             resp_pending,
    input logic                             wram_add_vld,
    input logic                             wram_add_rdy,
    input logic [wcache_pkg::wram_aw-1:0]   wram_add_add,
    input logic [wcache_pkg::n_port-1:0]    ptow_dat_vld
);
    int fail_cnt = 0;   // Failed assertion count

    // RAM address held with a stable value until taken
    property p_add_hold;
        @(posedge clk) disable iff (!rst_n)
            wram_add_vld && !wram_add_rdy |=> wram_add_vld && $stable(wram_add_add);
    endproperty

    property p_dat_in_work;
        @(posedge clk) disable iff (!rst_n)
            |ptow_dat_vld |-> state_work;
    endproperty

    // Single outstanding read
    property p_one_read;
        @(posedge clk) disable iff (!rst_n)
            resp_pending |-> !wram_add_vld;
    endproperty

    a_add_hold: assert property (p_add_hold) else begin
        $error("RAM address dropped or changed before wram_add_rdy");
        fail_cnt++;
    end

    a_dat_in_work: assert property (p_dat_in_work) else begin
        $error("Row data valid while the controller is not in work");
        fail_cnt++;
    end

    a_one_read: assert property (p_one_read) else begin
        $error("New RAM address issued while a read is still pending");
        fail_cnt++;
    end

endmodule

`default_nettype wire

//--- verification/tb_wcache.sv
// Weight cache testbench with RAM model, row stimulus, reference data and checking
`timescale 1ns/1ps
`default_nettype none

module tb_wcache;
    import wcache_pkg::*;

    localparam int bypass_len     = 6;
    localparam int seq_len        = 12;
    localparam int last_len       = 4;
    localparam int rand_len       = 40;
    localparam int pool_n         = 16;
    localparam int miss_lat_max   = 12;     // Issue, address, RAM delay and row stall
    localparam int req_total      = n_port * bypass_len + seq_len + last_len
                                    + n_port * rand_len + 1;
    localparam int timeout_cycles = 2 * req_total * miss_lat_max;

    logic                             clk;
    logic                             rst_n;
    logic                             cfg_info_vld;
    logic                             cfg_info_rdy;
    logic                             cfg_wbuf_ena;
    logic                             mtow_dat_vld;
    logic                             mtow_dat_rdy;
    logic [idx_w-1:0]                 mtow_dat_dat;
    logic [n_port-1:0]                ptow_add_vld;
    logic [n_port-1:0]                ptow_add_rdy;
    logic [n_port-1:0][wram_aw-1:0]   ptow_add_add;
    logic [n_port-1:0][idx_w-1:0]     ptow_add_buf;
    logic [n_port-1:0]                ptow_dat_vld;
    logic [n_port-1:0]                ptow_dat_rdy;
    logic [n_port-1:0][wram_dw-1:0]   ptow_dat_dat;
    logic                             wram_add_vld;
    logic                             wram_add_rdy;
    logic [wram_aw-1:0]               wram_add_add;
    logic                             wram_dat_vld;
    logic                             wram_dat_rdy;
    logic [wram_dw-1:0]               wram_dat_dat;

    integer             seed = 32'h4f6;
    string              test_name = "reset";
    logic [idx_w-1:0]   tag_list [$];           // Tags preloaded at configure
    logic [wram_dw-1:0] exp_q [n_port][$];      // Expected words per row
    int                 recv_cnt [n_port] = '{default: 0};
    int                 read_cnt = 0;
    int                 cycle_cnt;
    logic               rand_rdy = 1'b0;

    wcache_top dut0 (
        .clk (clk), .rst_n (rst_n),
        .cfg_info_vld (cfg_info_vld), .cfg_info_rdy (cfg_info_rdy),
        .cfg_wbuf_ena (cfg_wbuf_ena),
        .mtow_dat_vld (mtow_dat_vld), .mtow_dat_rdy (mtow_dat_rdy),
        .mtow_dat_dat (mtow_dat_dat),
        .ptow_add_vld (ptow_add_vld), .ptow_add_rdy (ptow_add_rdy),
        .ptow_add_add (ptow_add_add), .ptow_add_buf (ptow_add_buf),
        .ptow_dat_vld (ptow_dat_vld), .ptow_dat_rdy (ptow_dat_rdy),
        .ptow_dat_dat (ptow_dat_dat),
        .wram_add_vld (wram_add_vld), .wram_add_rdy (wram_add_rdy),
        .wram_add_add (wram_add_add),
        .wram_dat_vld (wram_dat_vld), .wram_dat_rdy (wram_dat_rdy),
        .wram_dat_dat (wram_dat_dat)
    );

    bind wcache_top wcache_assert u_assert (
        .clk (clk), .rst_n (rst_n), .state_work (state_work),
        .resp_pending (resp_pending), .wram_add_vld (wram_add_vld),
        .wram_add_rdy (wram_add_rdy), .wram_add_add (wram_add_add),
        .ptow_dat_vld (ptow_dat_vld)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // RAM contents, low address byte XOR high bits
    function automatic logic [wram_dw-1:0] ref_word(input logic [wram_aw-1:0] addr);
        return addr[7:0] ^ wram_dw'(addr[wram_aw-1:8]);
    endfunction

    function automatic logic [wram_aw-1:0] pool_addr(input int k);
        return {5'(k * 3 + 1), 8'(k * 17 + 5)};     // Distinct low byte per entry
    endfunction

    function automatic int pending_words();
        int n;
        n = 0;
        for (int r = 0; r < n_port; r++) begin
            n += exp_q[r].size();
        end
        return n;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input int exp, input int act);
        assert (exp == act)
            else stop_run($sformatf("[FAIL] %s expected %0h actual %0h", name, exp, act));
    endtask

    // ==================================================
    // Handshake drivers
    // ==================================================
    task automatic configure(input logic ena);
        @(negedge clk);
        cfg_info_vld = 1'b1;
        cfg_wbuf_ena = ena;
        do @(posedge clk); while (!cfg_info_rdy);
        @(negedge clk);
        cfg_info_vld = 1'b0;
        do @(posedge clk); while (!mtow_dat_rdy);   // Now in work
        foreach (tag_list[i]) begin
            @(negedge clk);
            mtow_dat_vld = 1'b1;
            mtow_dat_dat = tag_list[i];
            do @(posedge clk); while (!mtow_dat_rdy);
        end
        @(negedge clk);
        mtow_dat_vld = 1'b0;
    endtask

    task automatic leave_work();
        @(negedge clk);
        cfg_info_vld = 1'b1;
        @(negedge clk);
        cfg_info_vld = 1'b0;
        @(posedge clk);
        check_value("idle cfg_info_rdy", 1, cfg_info_rdy);
    endtask

    // Called on a falling edge, returns on one
    task automatic send_request(input int r, input logic [wram_aw-1:0] addr);
        ptow_add_vld[r] = 1'b1;
        ptow_add_add[r] = addr;
        ptow_add_buf[r] = addr[7:0];    // Tag is the low address byte
        do @(posedge clk); while (!ptow_add_rdy[r]);
        @(negedge clk);
        ptow_add_vld[r] = 1'b0;
    endtask

    task automatic bypass_row(input int r);
        for (int i = 0; i < bypass_len; i++) begin
            send_request(r, wram_aw'(r * 'h240 + (i % 3) * 'h11));  // Repeats addresses
        end
    endtask

    task automatic random_row(input int r);
        int gap;
        for (int i = 0; i < rand_len; i++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk);
            send_request(r, pool_addr($unsigned($random(seed)) % pool_n));
        end
    endtask

    task automatic run_rows(input bit random_mode);
        for (int r = 0; r < n_port; r++) begin
            automatic int rr = r;
            fork
                if (random_mode) random_row(rr);
                else bypass_row(rr);
            join_none
        end
        wait fork;
    endtask

    task automatic drain_rows();
        do @(negedge clk); while (pending_words() != 0);
    endtask

    // ==================================================
    // RAM model, row ready and comparison
    // ==================================================
    initial begin : ram_model
        logic [wram_aw-1:0] addr;
        int                 lat;
        @(negedge clk);
        wram_add_rdy = 1'b1;
        forever begin
            do @(posedge clk); while (!wram_add_vld);
            addr = wram_add_add;
            lat  = 1 + $unsigned($random(seed)) % 4;
            @(negedge clk);
            wram_add_rdy = 1'b0;
            repeat (lat - 1) @(negedge clk);
            wram_dat_vld = 1'b1;
            wram_dat_dat = ref_word(addr);
            do @(posedge clk); while (!wram_dat_rdy);
            @(negedge clk);
            wram_dat_vld = 1'b0;
            wram_add_rdy = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (rand_rdy) begin
            ptow_dat_rdy = n_port'($random(seed)) | n_port'($random(seed));  // Mostly high
        end else begin
            ptow_dat_rdy = '1;
        end
    end

    always @(posedge clk) begin
        logic [wram_dw-1:0] exp_w;
        for (int r = 0; r < n_port; r++) begin
            if (ptow_dat_vld[r] && ptow_dat_rdy[r]) begin
                assert (exp_q[r].size() != 0)
                    else stop_run($sformatf("Row %0d returned a word nobody asked for", r));
                if (exp_q[r].size() != 0) begin
                    exp_w = exp_q[r].pop_front();
                    recv_cnt[r]++;
                    check_value($sformatf("%s row %0d", test_name, r), exp_w, ptow_dat_dat[r]);
                end
            end
            if (ptow_add_vld[r] && ptow_add_rdy[r]) begin
                exp_q[r].push_back(ref_word(ptow_add_add[r]));
            end
        end
        if (wram_add_vld && wram_add_rdy) begin
            read_cnt++;
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        stop_run($sformatf("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt));
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin : main
        int                 reads0;
        int                 recv0 [n_port];
        logic [wram_aw-1:0] a;
        rst_n        = 1'b0;
        cfg_info_vld = 1'b0;
        cfg_wbuf_ena = 1'b0;
        mtow_dat_vld = 1'b0;
        mtow_dat_dat = '0;
        ptow_add_vld = '0;
        ptow_add_add = '0;
        ptow_add_buf = '0;
        ptow_dat_rdy = '1;
        wram_add_rdy = 1'b0;
        wram_dat_vld = 1'b0;
        wram_dat_dat = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        check_value("reset cfg_info_rdy", 1, cfg_info_rdy);
        check_value("reset ptow_dat_vld", 0, ptow_dat_vld);
        check_value("reset ptow_add_rdy", 0, ptow_add_rdy);
        check_value("reset wram_add_vld", 0, wram_add_vld);
        check_value("reset mtow_dat_rdy", 0, mtow_dat_rdy);
        check_value("reset wram_dat_rdy", 0, wram_dat_rdy);

        test_name = "bypass";
        configure(1'b0);
        reads0 = read_cnt;
        run_rows(1'b0);
        drain_rows();
        check_value("bypass reads", n_port * bypass_len, read_cnt - reads0);
        leave_work();

        test_name = "preload";
        tag_list = '{8'h10, 8'h21, 8'h32, 8'h43};
        configure(1'b1);
        reads0 = read_cnt;
        for (int i = 0; i < seq_len; i++) begin
            send_request(0, {5'(i % 4), tag_list[i % 4]});  // Tags rotate A B C D
        end
        drain_rows();
        check_value("preload reads", 4, read_cnt - reads0);

        test_name = "last access";
        reads0 = read_cnt;
        repeat (last_len) send_request(1, 13'h1a55);
        drain_rows();
        check_value("last access reads", 1, read_cnt - reads0);
        leave_work();

        test_name = "random";
        tag_list.delete();
        for (int k = 0; k < pool_n; k += 2) begin
            a = pool_addr(k);
            tag_list.push_back(a[7:0]);
        end
        configure(1'b1);
        recv0 = recv_cnt;
        rand_rdy = 1'b1;
        run_rows(1'b1);
        drain_rows();
        rand_rdy = 1'b0;
        for (int r = 0; r < n_port; r++) begin
            check_value($sformatf("random words row %0d", r), rand_len, recv_cnt[r] - recv0[r]);
        end
        leave_work();

        // Table must be empty after a fresh configure, this entry was preloaded and filled
        test_name = "reconfig";
        tag_list.delete();
        configure(1'b1);
        reads0 = read_cnt;
        send_request(2, pool_addr(0));
        drain_rows();
        check_value("reconfig reads", 1, read_cnt - reads0);

        if (dut0.u_assert.fail_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hw/wcache_pkg.sv
hw/wcache_ctrl.sv
hw/hit_table.sv
hw/miss_arbiter.sv
hw/port_return.sv
hw/wcache_top.sv
verification/wcache_assert.sv
verification/tb_wcache.sv
